//--- pcgen_defines.svh
// pc generator sizing constants
// widths of the stored pc and of the instruction bus read data,
// plus the value the current pc takes out of reset

`ifndef PCGEN_DEFINES_SVH
`define PCGEN_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pc sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define PCGEN_PC_W   31                        // holds address bits 31 to 1
`define PCGEN_PC_RST {`PCGEN_PC_W{1'b0}}      // boot fetch starts at address zero

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define PCGEN_IBUS_W 32                        // read data word, carries a vector entry pc

`endif

//--- pcgen_pkg.sv
// pc generator package
// pc word type and the state encodings of the abort and fetch-mask FSMs

`include "pcgen_defines.svh"

package pcgen_pkg;

  // one stored program counter, byte bit dropped
  typedef logic [`PCGEN_PC_W-1:0] pc_t;

  // delayed change of flow, waits for the instruction bus to drain
  typedef enum logic {
    abort_idle      = 1'b0,
    abort_wait_idle = 1'b1
  } abort_state_e;

  // fast branch outstanding until it retires
  typedef enum logic {
    mask_idle   = 1'b0,
    mask_active = 1'b1
  } mask_state_e;

endpackage

//--- pcgen_abort_fsm.sv
// pc generator abort FSM
// holds a delayed change of flow until the instruction bus is idle,
// stalling the pipeline meanwhile, then fires the abort fetch

`timescale 1ns/1ps

module pcgen_abort_fsm
  import pcgen_pkg::*;
(
  input  logic misc_clk,
  input  logic cpurst_b,
  input  logic br_chgflw_vld,
  input  logic rte_chgflw_vld,
  input  logic flush_chgflw_vld,
  input  logic exit_dbg,
  input  logic vector_chgflw_vld,
  input  logic ibus_idle,
  input  logic retire_mask,
  output logic wait_idle,
  output logic abort_fetch,
  output logic ctrl_stall,
  output logic vector_expt_taken
);

  abort_state_e cur_state;
  abort_state_e next_state;
  logic         delay_chgflw;
  logic         wait_trig;

  assign delay_chgflw = rte_chgflw_vld || flush_chgflw_vld || exit_dbg || vector_chgflw_vld;
  assign wait_trig    = delay_chgflw && !br_chgflw_vld;  // a fast branch goes out directly

  always_ff @(posedge misc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= abort_idle;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      abort_idle:
        if (wait_trig)
          next_state = abort_wait_idle;
      abort_wait_idle:
        if (ibus_idle)
          next_state = abort_idle;  // fetch issued this cycle
      default:
        next_state = abort_idle;
    endcase
  end

  assign wait_idle         = (cur_state == abort_wait_idle);
  assign abort_fetch       = wait_idle && ibus_idle;
  assign ctrl_stall        = wait_idle && !retire_mask;
  assign vector_expt_taken = (cur_state == abort_idle);

  // an abort fetch only follows a queued delayed change of flow
  a_abort_after_trig: assert property (@(posedge misc_clk) disable iff (!cpurst_b)
    abort_fetch |-> $past(wait_trig || wait_idle));

endmodule

//--- pcgen_fetch_mask_fsm.sv
// pc generator fetch-mask FSM
// blocks further fast-branch fetches while an earlier fast branch has
// not retired, and forms the instruction fetch strobe

`timescale 1ns/1ps

module pcgen_fetch_mask_fsm
  import pcgen_pkg::*;
(
  input  logic misc_clk,
  input  logic cpurst_b,
  input  logic br_chgflw_vld,
  input  logic retire,
  input  logic flush,
  input  logic abort_fetch,
  input  logic ibus_idle,
  output logic inst_fetch,
  output logic ibus_idle_out
);

  mask_state_e cur_state;
  mask_state_e next_state;
  logic        mask_trig;
  logic        fetch_mask;

  assign mask_trig = br_chgflw_vld && !retire;  // branch retiring now leaves nothing pending

  always_ff @(posedge misc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= mask_idle;
    else if (flush)
      cur_state <= mask_idle;  // flush beats everything
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      mask_idle:
        if (mask_trig)
          next_state = mask_active;
      mask_active:
        if (retire)
          next_state = mask_idle;
      default:
        next_state = mask_idle;
    endcase
  end

  assign fetch_mask    = (cur_state == mask_active);
  assign ibus_idle_out = ibus_idle || fetch_mask;  // no new fetch can be in flight
  assign inst_fetch    = abort_fetch || (br_chgflw_vld && !fetch_mask);

  // the mask never survives a flush
  a_flush_clears_mask: assert property (@(posedge misc_clk) disable iff (!cpurst_b)
    flush |=> !fetch_mask);

endmodule

//--- pcgen_fetch_addr_mux.sv
// pc generator fetch address select
// picks the next instruction fetch address for the fast path, with the
// current pc taking over while a delayed change of flow is pending

`timescale 1ns/1ps

module pcgen_fetch_addr_mux
  import pcgen_pkg::*;
(
  input  logic branch_sel,
  input  logic jmp_sel,
  input  logic vector_ibus_req,
  input  logic wait_idle,
  input  pc_t  add_pc,
  input  pc_t  reg_pc,
  input  pc_t  cur_pc,
  output pc_t  fetch_addr
);

  pc_t  inc_pc;
  logic cur_sel;

  // the branch unit adder already holds pc plus instruction size
  assign inc_pc  = add_pc;
  assign cur_sel = wait_idle || vector_ibus_req;  // refetch from the held pc

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // priority select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    if (cur_sel)
      fetch_addr = cur_pc;
    else if (branch_sel)
      fetch_addr = add_pc;  // taken conditional branch
    else if (jmp_sel)
      fetch_addr = reg_pc;  // register jump target
    else
      fetch_addr = inc_pc;
  end

  // branch unit raises at most one target select per cycle
  always_comb
  begin
    a_one_branch_sel: assert (!(branch_sel && jmp_sel))
      else $error("branch_sel and jmp_sel both high");
  end

endmodule

//--- pcgen_cur_pc_unit.sv
// pc generator current pc register
// selects the delayed-path address, applies the writeback overrides
// and updates the current pc when an update is valid

`timescale 1ns/1ps

`include "pcgen_defines.svh"

module pcgen_cur_pc_unit
  import pcgen_pkg::*;
(
  input  logic                     misc_clk,
  input  logic                     cpurst_b,
  input  logic                     normal_retire,
  input  logic                     exit_dbg,
  input  logic                     rte_sel,
  input  logic                     rte_pc_sel_had,
  input  logic                     vector_buf_vbr,
  input  logic                     vector_cur_pc_vld,
  input  logic                     curpc_update,
  input  logic                     switch_ld_pc,
  input  pc_t                      fetch_addr,
  input  pc_t                      had_pc,
  input  pc_t                      epc,
  input  pc_t                      vector_enter_addr,
  input  pc_t                      fast_retire_load_pc,
  input  pc_t                      pc_updt_val,
  input  logic [`PCGEN_IBUS_W-1:0] ibus_data,
  output pc_t                      cur_pc,
  output pc_t                      retire_updt_pc
);

  logic updt_vld;
  logic sel_had;
  logic sel_vec;
  logic sel_ibus;
  logic sel_epc;
  logic delay_sel;
  pc_t  delay_addr;
  pc_t  pre_wb_pc;
  pc_t  next_pc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // update enable
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign updt_vld = normal_retire
                 || exit_dbg
                 || vector_cur_pc_vld
                 || vector_buf_vbr
                 || curpc_update
                 || switch_ld_pc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // delayed path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign sel_had  = exit_dbg || (rte_sel && rte_pc_sel_had);  // return into debug pc
  assign sel_vec  = vector_buf_vbr;
  assign sel_ibus = vector_cur_pc_vld;  // entry pc read from the vector table
  assign sel_epc  = rte_sel && !rte_pc_sel_had;

  assign delay_addr = ({`PCGEN_PC_W{sel_had}}  & had_pc)
                    | ({`PCGEN_PC_W{sel_vec}}  & vector_enter_addr)
                    | ({`PCGEN_PC_W{sel_ibus}} & ibus_data[`PCGEN_IBUS_W-1:1])
                    | ({`PCGEN_PC_W{sel_epc}}  & epc);

  assign delay_sel = updt_vld && (sel_had || sel_vec || sel_ibus || sel_epc);

  assign retire_updt_pc = updt_vld ? fetch_addr : cur_pc;
  assign pre_wb_pc      = delay_sel ? delay_addr : retire_updt_pc;

  // writeback knows the real pc after a fast-retired load or a switch
  always_comb
  begin
    if (curpc_update)
      next_pc = fast_retire_load_pc;
    else if (switch_ld_pc)
      next_pc = pc_updt_val;
    else
      next_pc = pre_wb_pc;
  end

  always_ff @(posedge misc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_pc <= `PCGEN_PC_RST;
    else if (updt_vld)
      cur_pc <= next_pc;
  end

  // writeback never drives both overrides in one cycle
  a_one_wb_override: assert property (@(posedge misc_clk) disable iff (!cpurst_b)
    !(curpc_update && switch_ld_pc));

endmodule

//--- pcgen_top.sv
// pc generator top level
// connects the abort FSM, fetch-mask FSM, fetch address select
// and current pc register of the in-order core

`timescale 1ns/1ps

`include "pcgen_defines.svh"

module pcgen_top
  import pcgen_pkg::*;
(
  input  logic                     misc_clk,
  input  logic                     cpurst_b,
  input  logic                     br_chgflw_vld,
  input  logic                     rte_chgflw_vld,
  input  logic                     flush_chgflw_vld,
  input  logic                     exit_dbg,
  input  logic                     vector_chgflw_vld,
  input  logic                     ibus_idle,
  input  logic                     retire_mask,
  input  logic                     retire,
  input  logic                     flush,
  input  logic                     branch_sel,
  input  logic                     jmp_sel,
  input  logic                     vector_ibus_req,
  input  pc_t                      add_pc,
  input  pc_t                      reg_pc,
  input  logic                     normal_retire,
  input  logic                     rte_sel,
  input  logic                     rte_pc_sel_had,
  input  logic                     vector_buf_vbr,
  input  logic                     vector_cur_pc_vld,
  input  logic                     curpc_update,
  input  logic                     switch_ld_pc,
  input  pc_t                      had_pc,
  input  pc_t                      epc,
  input  pc_t                      vector_enter_addr,
  input  pc_t                      fast_retire_load_pc,
  input  pc_t                      pc_updt_val,
  input  logic [`PCGEN_IBUS_W-1:0] ibus_data,
  output logic                     data_fetch,
  output pc_t                      fetch_addr,
  output logic                     inst_fetch,
  output logic                     ctrl_stall,
  output pc_t                      cur_pc,
  output pc_t                      retire_updt_pc,
  output logic                     ibus_idle_out,
  output logic                     vector_expt_taken
);

  logic wait_idle;
  logic abort_fetch;

  assign data_fetch = vector_ibus_req;  // vector table read uses the instruction bus

  pcgen_abort_fsm i_abort_fsm (
    .misc_clk          (misc_clk),
    .cpurst_b          (cpurst_b),
    .br_chgflw_vld     (br_chgflw_vld),
    .rte_chgflw_vld    (rte_chgflw_vld),
    .flush_chgflw_vld  (flush_chgflw_vld),
    .exit_dbg          (exit_dbg),
    .vector_chgflw_vld (vector_chgflw_vld),
    .ibus_idle         (ibus_idle),
    .retire_mask       (retire_mask),
    .wait_idle         (wait_idle),
    .abort_fetch       (abort_fetch),
    .ctrl_stall        (ctrl_stall),
    .vector_expt_taken (vector_expt_taken)
  );

  pcgen_fetch_mask_fsm i_fetch_mask_fsm (
    .misc_clk      (misc_clk),
    .cpurst_b      (cpurst_b),
    .br_chgflw_vld (br_chgflw_vld),
    .retire        (retire),
    .flush         (flush),
    .abort_fetch   (abort_fetch),
    .ibus_idle     (ibus_idle),
    .inst_fetch    (inst_fetch),
    .ibus_idle_out (ibus_idle_out)
  );

  pcgen_fetch_addr_mux i_fetch_addr_mux (
    .branch_sel      (branch_sel),
    .jmp_sel         (jmp_sel),
    .vector_ibus_req (vector_ibus_req),
    .wait_idle       (wait_idle),
    .add_pc          (add_pc),
    .reg_pc          (reg_pc),
    .cur_pc          (cur_pc),
    .fetch_addr      (fetch_addr)
  );

  pcgen_cur_pc_unit i_cur_pc_unit (
    .misc_clk            (misc_clk),
    .cpurst_b            (cpurst_b),
    .normal_retire       (normal_retire),
    .exit_dbg            (exit_dbg),
    .rte_sel             (rte_sel),
    .rte_pc_sel_had      (rte_pc_sel_had),
    .vector_buf_vbr      (vector_buf_vbr),
    .vector_cur_pc_vld   (vector_cur_pc_vld),
    .curpc_update        (curpc_update),
    .switch_ld_pc        (switch_ld_pc),
    .fetch_addr          (fetch_addr),
    .had_pc              (had_pc),
    .epc                 (epc),
    .vector_enter_addr   (vector_enter_addr),
    .fast_retire_load_pc (fast_retire_load_pc),
    .pc_updt_val         (pc_updt_val),
    .ibus_data           (ibus_data),
    .cur_pc              (cur_pc),
    .retire_updt_pc      (retire_updt_pc)
  );

endmodule

//--- tb_pcgen_cases.svh
// pc generator test table
// one row per clock cycle, included into the testbench case loader
// the columns are the name, the inputs held high, the expected {vet, idle_out, stall, fetch},
// the fetch address source, and the source cur_pc loads at the end of the row

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset and fast path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
add_case("reset_state",    19'h0,                  e_vet,           fa_add, pc_keep);
add_case("bus_idle",       m_idle,                 e_idle | e_vet,  fa_add, pc_keep);
add_case("branch_add",     m_br | m_bsel | m_ret,  e_fetch | e_vet, fa_add, pc_keep);
add_case("jump_reg",       m_br | m_jsel | m_ret,  e_fetch | e_vet, fa_reg, pc_keep);

// outstanding branch blocks the next one until retire or flush
add_case("mask_set",       m_br | m_bsel,          e_fetch | e_vet, fa_add, pc_keep);
add_case("mask_block",     m_br | m_bsel,          e_idle | e_vet,  fa_add, pc_keep);
add_case("mask_retire",    m_ret,                  e_idle | e_vet,  fa_add, pc_keep);
add_case("mask_cleared",   m_br | m_bsel | m_ret,  e_fetch | e_vet, fa_add, pc_keep);
add_case("flush_mask_set", m_br | m_bsel,          e_fetch | e_vet, fa_add, pc_keep);
add_case("flush_mask",     m_flush,                e_idle | e_vet,  fa_add, pc_keep);
add_case("flush_cleared",  m_br | m_bsel | m_ret,  e_fetch | e_vet, fa_add, pc_keep);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// retire and delayed path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
add_case("retire_add",     m_nret,                 e_vet,           fa_add, pc_add);
add_case("retire_jump",    m_nret | m_jsel,        e_vet,           fa_reg, pc_reg);
add_case("retire_epc",     m_nret | m_rsel,        e_vet,           fa_add, pc_epc);
add_case("rte_request",    m_rte,                  e_vet,           fa_add, pc_keep);
add_case("rte_wait_a",     19'h0,                  e_stall,         fa_cur, pc_keep);
add_case("rte_wait_b",     19'h0,                  e_stall,         fa_cur, pc_keep);
add_case("rte_fetch",      m_idle,       e_fetch | e_stall | e_idle, fa_cur, pc_keep);
add_case("rte_done",       19'h0,                  e_vet,           fa_add, pc_keep);
add_case("flush_request",  m_flc,                  e_vet,           fa_add, pc_keep);
add_case("stall_masked",   m_rmask,                4'h0,            fa_cur, pc_keep);
add_case("flush_fetch",    m_idle,       e_fetch | e_stall | e_idle, fa_cur, pc_keep);
add_case("branch_over_rte", m_rte | m_br | m_bsel | m_ret, e_fetch | e_vet, fa_add, pc_keep);
add_case("no_wait_after",  19'h0,                  e_vet,           fa_add, pc_keep);

// writeback overrides win over every other source
add_case("fast_retire_ld", m_cupd | m_nret | m_rsel, e_vet,         fa_add, pc_frl);
add_case("switch_load",    m_swld | m_xdbg,        e_vet,           fa_add, pc_upd);
add_case("exit_dbg_fetch", m_idle,       e_fetch | e_stall | e_idle, fa_cur, pc_keep);
add_case("vector_req_cur", m_vreq,                 e_vet,           fa_cur, pc_keep);

// delayed-path sources with no override active
add_case("rte_had",        m_nret | m_rsel | m_rhad, e_vet,         fa_add, pc_had);
add_case("vector_vbr",     m_vbr,                  e_vet,           fa_add, pc_vec);
add_case("vector_ibus",    m_vcur,                 e_vet,           fa_add, pc_ibus);
add_case("final_pc",       19'h0,                  e_vet,           fa_add, pc_keep);

//--- tb_pcgen_top.sv
// pc generator testbench
// steps the top level through a table of one-cycle tests, comparing the
// fetch strobes, stall, fetch address, current pc and retire pc against the table

`timescale 1ns/1ps

`include "pcgen_defines.svh"

module tb_pcgen_top
  import pcgen_pkg::*;
();

  localparam int reset_cycles = 8;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // table encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam logic [18:0] m_br    = 19'h00001;
  localparam logic [18:0] m_rte   = 19'h00002;
  localparam logic [18:0] m_flc   = 19'h00004;
  localparam logic [18:0] m_xdbg  = 19'h00008;
  localparam logic [18:0] m_vec   = 19'h00010;
  localparam logic [18:0] m_idle  = 19'h00020;
  localparam logic [18:0] m_rmask = 19'h00040;
  localparam logic [18:0] m_ret   = 19'h00080;
  localparam logic [18:0] m_flush = 19'h00100;
  localparam logic [18:0] m_bsel  = 19'h00200;
  localparam logic [18:0] m_jsel  = 19'h00400;
  localparam logic [18:0] m_vreq  = 19'h00800;
  localparam logic [18:0] m_nret  = 19'h01000;
  localparam logic [18:0] m_rsel  = 19'h02000;
  localparam logic [18:0] m_rhad  = 19'h04000;
  localparam logic [18:0] m_vbr   = 19'h08000;
  localparam logic [18:0] m_vcur  = 19'h10000;
  localparam logic [18:0] m_cupd  = 19'h20000;
  localparam logic [18:0] m_swld  = 19'h40000;

  // any of these loads cur_pc at the next edge
  localparam logic [18:0] m_updt  = m_nret | m_xdbg | m_vcur | m_vbr | m_cupd | m_swld;

  localparam logic [3:0] e_fetch = 4'b0001;
  localparam logic [3:0] e_stall = 4'b0010;
  localparam logic [3:0] e_idle  = 4'b0100;  // ibus_idle_out
  localparam logic [3:0] e_vet   = 4'b1000;

  localparam logic [1:0] fa_add = 2'd0;
  localparam logic [1:0] fa_reg = 2'd1;
  localparam logic [1:0] fa_cur = 2'd2;

  localparam logic [3:0] pc_keep = 4'd0;
  localparam logic [3:0] pc_add  = 4'd1;
  localparam logic [3:0] pc_reg  = 4'd2;
  localparam logic [3:0] pc_epc  = 4'd3;
  localparam logic [3:0] pc_frl  = 4'd4;
  localparam logic [3:0] pc_upd  = 4'd5;
  localparam logic [3:0] pc_had  = 4'd6;
  localparam logic [3:0] pc_vec  = 4'd7;
  localparam logic [3:0] pc_ibus = 4'd8;

  logic misc_clk;
  logic cpurst_b;
  logic [18:0] ctrl_bus;
  logic br_chgflw_vld, rte_chgflw_vld, flush_chgflw_vld, exit_dbg, vector_chgflw_vld;
  logic ibus_idle, retire_mask, retire, flush, branch_sel, jmp_sel, vector_ibus_req;
  logic normal_retire, rte_sel, rte_pc_sel_had, vector_buf_vbr, vector_cur_pc_vld;
  logic curpc_update, switch_ld_pc;
  pc_t  add_pc, reg_pc, had_pc, epc, vector_enter_addr, fast_retire_load_pc, pc_updt_val;
  logic [`PCGEN_IBUS_W-1:0] ibus_data;
  logic data_fetch, inst_fetch, ctrl_stall, ibus_idle_out, vector_expt_taken;
  pc_t  fetch_addr, cur_pc, retire_updt_pc;

  string       case_name[$];
  logic [18:0] case_ctrl[$];
  logic [3:0]  case_flags[$];
  logic [1:0]  case_fa[$];
  logic [3:0]  case_pc[$];

  logic [31:0] lfsr_state = 32'h00293c4d;
  int          cycle_cnt = 0;
  int          fail_tests = 0;
  int          row_errs;
  logic [3:0]  flags_now;
  logic        exp_df;
  pc_t         exp_pc;
  pc_t         exp_fa;
  pc_t         exp_rup;

  assign {switch_ld_pc, curpc_update, vector_cur_pc_vld, vector_buf_vbr, rte_pc_sel_had,
          rte_sel, normal_retire, vector_ibus_req, jmp_sel, branch_sel, flush, retire,
          retire_mask, ibus_idle, vector_chgflw_vld, exit_dbg, flush_chgflw_vld,
          rte_chgflw_vld, br_chgflw_vld} = ctrl_bus;

  pcgen_top i_pcgen_top (.*);

  initial
  begin
    misc_clk = 1'b0;
    forever #20 misc_clk = ~misc_clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    else
      return s >> 1;
  endfunction

  task draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task add_case(input string name, input logic [18:0] ctrl, input logic [3:0] flags,
                input logic [1:0] fa, input logic [3:0] pcs);
    case_name.push_back(name);
    case_ctrl.push_back(ctrl);
    case_flags.push_back(flags);
    case_fa.push_back(fa);
    case_pc.push_back(pcs);
  endtask

  task load_cases();
    `include "tb_pcgen_cases.svh"
  endtask

  // fresh address data every row so a stale source cannot match
  task drive_row(input logic [18:0] ctrl);
    logic [31:0] w;
    ctrl_bus <= ctrl;
    draw_bits(`PCGEN_PC_W, w);
    add_pc <= w[`PCGEN_PC_W-1:0];
    draw_bits(`PCGEN_PC_W, w);
    reg_pc <= w[`PCGEN_PC_W-1:0];
    draw_bits(`PCGEN_PC_W, w);
    had_pc <= w[`PCGEN_PC_W-1:0];
    draw_bits(`PCGEN_PC_W, w);
    epc <= w[`PCGEN_PC_W-1:0];
    draw_bits(`PCGEN_PC_W, w);
    vector_enter_addr <= w[`PCGEN_PC_W-1:0];
    draw_bits(`PCGEN_PC_W, w);
    fast_retire_load_pc <= w[`PCGEN_PC_W-1:0];
    draw_bits(`PCGEN_PC_W, w);
    pc_updt_val <= w[`PCGEN_PC_W-1:0];
    draw_bits(`PCGEN_IBUS_W, w);
    ibus_data <= w;
  endtask

  always @(posedge misc_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= case_name.size() * 8 + reset_cycles + 20)
    begin
      $display("run did not finish within %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // table loop
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    cpurst_b = 1'b0;
    ctrl_bus = '0;
    add_pc = '0;
    reg_pc = '0;
    had_pc = '0;
    epc = '0;
    vector_enter_addr = '0;
    fast_retire_load_pc = '0;
    pc_updt_val = '0;
    ibus_data = '0;
    exp_pc = `PCGEN_PC_RST;
    load_cases();
    repeat (reset_cycles) @(posedge misc_clk);
    cpurst_b <= 1'b1;
    for (int i = 0; i < case_name.size(); i++)
    begin
      @(posedge misc_clk);
      drive_row(case_ctrl[i]);
      @(negedge misc_clk);  // outputs settled mid-cycle
      row_errs = 0;
      flags_now = {vector_expt_taken, ibus_idle_out, ctrl_stall, inst_fetch};
      case (case_fa[i])
        fa_reg:  exp_fa = reg_pc;
        fa_cur:  exp_fa = exp_pc;
        default: exp_fa = add_pc;
      endcase
      exp_rup = ((case_ctrl[i] & m_updt) != '0) ? exp_fa : exp_pc;
      exp_df  = ((case_ctrl[i] & m_vreq) != '0);
      if (flags_now !== case_flags[i])
      begin
        $display("FAILED %s vet/idle/stall/fetch expected %b actual %b",
                 case_name[i], case_flags[i], flags_now);
        row_errs++;
      end
      if (fetch_addr !== exp_fa)
      begin
        $display("FAILED %s fetch_addr expected %h actual %h", case_name[i], exp_fa, fetch_addr);
        row_errs++;
      end
      if (cur_pc !== exp_pc)
      begin
        $display("FAILED %s cur_pc expected %h actual %h", case_name[i], exp_pc, cur_pc);
        row_errs++;
      end
      if (retire_updt_pc !== exp_rup)
      begin
        $display("FAILED %s retire_updt_pc expected %h actual %h",
                 case_name[i], exp_rup, retire_updt_pc);
        row_errs++;
      end
      if (data_fetch !== exp_df)
      begin
        $display("FAILED %s data_fetch expected %b actual %b", case_name[i], exp_df, data_fetch);
        row_errs++;
      end
      case (case_pc[i])  // source the next edge loads into cur_pc
        pc_add:  exp_pc = add_pc;
        pc_reg:  exp_pc = reg_pc;
        pc_epc:  exp_pc = epc;
        pc_frl:  exp_pc = fast_retire_load_pc;
        pc_upd:  exp_pc = pc_updt_val;
        pc_had:  exp_pc = had_pc;
        pc_vec:  exp_pc = vector_enter_addr;
        pc_ibus: exp_pc = ibus_data[`PCGEN_IBUS_W-1:1];
        default: exp_pc = exp_pc;
      endcase
      if (row_errs == 0)
        $display("passed %s", case_name[i]);
      else
      begin
        fail_tests++;
        $display("test %s had %0d mismatches", case_name[i], row_errs);
      end
    end
    $display("tests %0d passed %0d failed %0d", case_name.size(),
             case_name.size() - fail_tests, fail_tests);
    if (fail_tests == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- project.f
+incdir+.
pcgen_pkg.sv
pcgen_abort_fsm.sv
pcgen_fetch_mask_fsm.sv
pcgen_fetch_addr_mux.sv
pcgen_cur_pc_unit.sv
pcgen_top.sv
tb_pcgen_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_pcgen_top
FILELIST = project.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
